// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f verilog.f --top-module tb_ibuf -Mdir obj_dir
	./obj_dir/Vtb_ibuf | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: ibuf_group_select.sv
`default_nettype none

`include "ibuf_macros.svh"

module ibuf_group_select
  import ibuf_pkg::*;
(
  input  logic                     i_flush,
  input  logic                     i_disp_ready,

  input  inst_word_u               i_slot_word    [`IBUF_DISP],
  input  logic [`IBUF_DISP-1:0]    i_slot_rvc,
  input  logic [`IBUF_DISP-1:0]    i_slot_avail,
  input  logic [`IBUF_VADDR_W-1:0] i_slot_pc      [`IBUF_DISP],
  input  logic [`IBUF_POS_W:0]     i_slot_end_pos [`IBUF_DISP],
  input  inst_cat_t                i_slot_cat     [`IBUF_DISP],

  output logic                     o_disp_valid,
  output logic [`IBUF_DISP-1:0]    o_disp_slot_valid,
  output logic [31:0]              o_disp_inst    [`IBUF_DISP],
  output logic [`IBUF_DISP-1:0]    o_disp_rvc,
  output inst_cat_t                o_disp_cat     [`IBUF_DISP],
  output logic [`IBUF_VADDR_W-1:0] o_disp_pc      [`IBUF_DISP],

  output logic                     o_fire,
  output logic [`IBUF_POS_W:0]     o_adv_parcels
);

  logic [`IBUF_DISP-1:0] w_take;
  logic [`IBUF_DISP-1:0] w_slot_valid;
  logic [`IBUF_POS_W-1:0] w_head_pos;
  logic [`IBUF_POS_W:0]   w_last_end;

  // Slot 0 always starts at the head, so its PC carries the head position
  assign w_head_pos = i_slot_pc[0][`IBUF_POS_W:1];

  // ========================================
  // Group limits
  // ========================================
  always_comb begin
    logic                      stop;
    logic                      is_mem;
    logic [$clog2(`IBUF_DISP):0] mem_cnt;

    stop       = 1'b0;
    mem_cnt    = '0;
    w_take     = '0;
    w_last_end = {1'b0, w_head_pos};
    for (int s = 0; s < `IBUF_DISP; s++) begin
      is_mem = (i_slot_cat[s] == CAT_LD) || (i_slot_cat[s] == CAT_ST);
      if (stop || !i_slot_avail[s] || (is_mem && (mem_cnt == `IBUF_MEM_DISP))) begin
        stop = 1'b1; // stop before this slot
      end else begin
        w_take[s]  = 1'b1;
        w_last_end = i_slot_end_pos[s];
        if (is_mem) begin
          mem_cnt = mem_cnt + 1'b1;
        end
        if ((i_slot_cat[s] == CAT_BR) || (i_slot_cat[s] == CAT_ILLEGAL)) begin
          stop = 1'b1; // stop after this slot
        end
      end
    end
  end

  assign w_slot_valid  = w_take & {`IBUF_DISP{~i_flush}};
  assign o_disp_valid  = |w_slot_valid;
  assign o_fire        = o_disp_valid & i_disp_ready;
  assign o_adv_parcels = w_last_end - {1'b0, w_head_pos};

  // ========================================
  // Dispatch outputs
  // ========================================
  assign o_disp_slot_valid = w_slot_valid;
  assign o_disp_rvc        = i_slot_rvc & w_slot_valid;

  for (genvar s = 0; s < `IBUF_DISP; s++) begin : g_out
    assign o_disp_inst[s] = w_slot_valid[s] ? i_slot_word[s] : 32'h0;
    assign o_disp_cat[s]  = w_slot_valid[s] ? i_slot_cat[s] : CAT_ARITH;
    assign o_disp_pc[s]   = w_slot_valid[s] ? i_slot_pc[s] : '0;
  end

endmodule

`default_nettype wire

// File: ibuf_inst_classify.sv
`default_nettype none

`include "ibuf_macros.svh"

module ibuf_inst_classify
  import ibuf_pkg::*;
(
  input  inst_word_u            i_slot_word [`IBUF_DISP],
  input  logic [`IBUF_DISP-1:0] i_slot_rvc,
  output inst_cat_t             o_slot_cat  [`IBUF_DISP]
);

  for (genvar s = 0; s < `IBUF_DISP; s++) begin : g_slot
    always_comb begin
      if (i_slot_rvc[s]) begin
        // Quadrant from opcode[1:0], RVC funct3 sits at bits 15:13
        case ({i_slot_word[s].fields.opcode[1:0], i_slot_word[s].parcels.lo[15:13]})
          5'b00_010: o_slot_cat[s] = CAT_LD;   // C.LW
          5'b00_110: o_slot_cat[s] = CAT_ST;   // C.SW
          5'b01_101,                           // C.J
          5'b01_110,                           // C.BEQZ
          5'b01_111: o_slot_cat[s] = CAT_BR;   // C.BNEZ
          default:   o_slot_cat[s] = CAT_ARITH;
        endcase
      end else begin
        case (i_slot_word[s].fields.opcode)
          7'b0000011: o_slot_cat[s] = CAT_LD;  // LOAD
          7'b0100011: o_slot_cat[s] = CAT_ST;  // STORE
          7'b1100011,                          // BRANCH
          7'b1101111,                          // JAL
          7'b1100111: o_slot_cat[s] = CAT_BR;  // JALR
          7'b0110011,                          // OP
          7'b0010011,                          // OP-IMM
          7'b0110111,                          // LUI
          7'b0010111: o_slot_cat[s] = CAT_ARITH; // AUIPC
          default:    o_slot_cat[s] = CAT_ILLEGAL;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: ibuf_line_queue.sv
`default_nettype none

`include "ibuf_macros.svh"

module ibuf_line_queue (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_flush,

  input  logic                     i_fetch_valid,
  input  logic [`IBUF_VADDR_W-1:0] i_fetch_pc,
  input  logic [`IBUF_LINE_W-1:0]  i_fetch_line,
  output logic                     o_fetch_ready,

  input  logic                     i_fire,
  input  logic [`IBUF_POS_W:0]     i_adv_parcels,

  output logic [`IBUF_LINE_W-1:0]  o_head_line,
  output logic [`IBUF_LINE_W-1:0]  o_next_line,
  output logic                     o_head_valid,
  output logic                     o_next_valid,
  output logic [`IBUF_VADDR_W-1:0] o_head_pc,
  output logic [`IBUF_POS_W-1:0]   o_head_pos
);

  logic [`IBUF_LINE_W-1:0]  r_line [`IBUF_DEPTH];
  logic [`IBUF_VADDR_W-1:0] r_pc   [`IBUF_DEPTH];
  logic [`IBUF_DEPTH-1:0]   r_valid;

  logic [`IBUF_PTR_W-1:0]   r_inptr;
  logic [`IBUF_PTR_W-1:0]   r_outptr;
  logic [`IBUF_PTR_W-1:0]   w_outptr_p1;
  logic [`IBUF_POS_W-1:0]   r_head_pos;

  logic [`IBUF_POS_W:0]     w_pos_sum;
  logic                     w_in_fire;
  logic                     w_pop;
  logic                     w_empty;

  assign o_fetch_ready = ~&r_valid;
  assign w_in_fire     = i_fetch_valid & o_fetch_ready & ~i_flush;
  assign w_empty       = ~|r_valid;

  // Head position plus consumed parcels, MSB set means head line is done
  assign w_pos_sum = {1'b0, r_head_pos} + i_adv_parcels;
  assign w_pop     = i_fire & w_pos_sum[`IBUF_POS_W];

  assign w_outptr_p1 = r_outptr + 1'b1;

  // ========================================
  // Line storage
  // ========================================
  always_ff @(posedge i_clk) begin
    if (w_in_fire) begin
      r_line[r_inptr] <= i_fetch_line;
      r_pc[r_inptr]   <= i_fetch_pc;
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid  <= '0;
      r_inptr  <= '0;
      r_outptr <= '0;
    end else if (i_flush) begin
      r_valid  <= '0;
      r_inptr  <= '0;
      r_outptr <= '0;
    end else begin
      if (w_in_fire) begin
        r_valid[r_inptr] <= 1'b1;
        r_inptr          <= r_inptr + 1'b1;
      end
      if (w_pop) begin
        r_valid[r_outptr] <= 1'b0; // never the slot being written, queue was not full
        r_outptr          <= w_outptr_p1;
      end
    end
  end

  // ========================================
  // Head parcel position
  // ========================================
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head_pos <= '0;
    end else if (i_flush) begin
      r_head_pos <= '0;
    end else if (w_in_fire & w_empty) begin
      // First line of a stream may start mid-line
      r_head_pos <= i_fetch_pc[`IBUF_POS_W:1];
    end else if (i_fire) begin
      r_head_pos <= w_pos_sum[`IBUF_POS_W-1:0]; // carry into next line on pop
    end
  end

  assign o_head_line  = r_line[r_outptr];
  assign o_next_line  = r_line[w_outptr_p1];
  assign o_head_valid = r_valid[r_outptr];
  assign o_next_valid = r_valid[w_outptr_p1];
  assign o_head_pc    = r_pc[r_outptr];
  assign o_head_pos   = r_head_pos;

endmodule

`default_nettype wire

// File: ibuf_macros.svh
`ifndef IBUF_MACROS_SVH
`define IBUF_MACROS_SVH

// Fetch line geometry
`define IBUF_LINE_W   128
`define IBUF_PARCELS  8
`define IBUF_POS_W    3

// Line queue
`define IBUF_DEPTH    4
`define IBUF_PTR_W    2

// Dispatch group limits
`define IBUF_DISP     4
`define IBUF_MEM_DISP 2

`define IBUF_VADDR_W  32

`endif

// File: ibuf_parcel_extract.sv
`default_nettype none

`include "ibuf_macros.svh"

module ibuf_parcel_extract
  import ibuf_pkg::*;
(
  input  logic [`IBUF_LINE_W-1:0]  i_head_line,
  input  logic [`IBUF_LINE_W-1:0]  i_next_line,
  input  logic                     i_head_valid,
  input  logic                     i_next_valid,
  input  logic [`IBUF_VADDR_W-1:0] i_head_pc,
  input  logic [`IBUF_POS_W-1:0]   i_head_pos,

  output inst_word_u               o_slot_word    [`IBUF_DISP],
  output logic [`IBUF_DISP-1:0]    o_slot_rvc,
  output logic [`IBUF_DISP-1:0]    o_slot_avail,
  output logic [`IBUF_VADDR_W-1:0] o_slot_pc      [`IBUF_DISP],
  output logic [`IBUF_POS_W:0]     o_slot_end_pos [`IBUF_DISP]
);

  // Parcels 0..7 from head line, 8..15 from next line
  logic [15:0]                   w_parcel [2*`IBUF_PARCELS];
  logic [2*`IBUF_PARCELS-1:0]    w_parcel_ok;
  logic [`IBUF_VADDR_W-1:0]      w_line_base;

  for (genvar p = 0; p < `IBUF_PARCELS; p++) begin : g_parcel
    assign w_parcel[p]                 = i_head_line[p*16 +: 16];
    assign w_parcel[p + `IBUF_PARCELS] = i_next_line[p*16 +: 16];
  end

  assign w_parcel_ok = {{`IBUF_PARCELS{i_next_valid}}, {`IBUF_PARCELS{i_head_valid}}};

  // Head line PC with the in-line offset cleared
  assign w_line_base = {i_head_pc[`IBUF_VADDR_W-1:`IBUF_POS_W+1], {(`IBUF_POS_W+1){1'b0}}};

  // ========================================
  // Slot walk
  // ========================================
  always_comb begin
    logic [`IBUF_POS_W:0] pos;
    logic [`IBUF_POS_W:0] pos_hi;
    logic [15:0]          lo_parcel;
    logic [15:0]          hi_parcel;
    logic                 rvc;
    logic                 chain;

    pos   = {1'b0, i_head_pos};
    chain = 1'b1;
    for (int s = 0; s < `IBUF_DISP; s++) begin
      pos_hi    = pos + 1'b1;
      lo_parcel = w_parcel[pos];
      hi_parcel = w_parcel[pos_hi];
      rvc       = (lo_parcel[1:0] != 2'b11);

      o_slot_word[s].parcels.lo = lo_parcel;
      o_slot_word[s].parcels.hi = rvc ? 16'h0 : hi_parcel; // upper half unused for RVC
      o_slot_rvc[s]             = rvc;

      // Every parcel in a valid line, and no gap before this slot
      chain           = chain & w_parcel_ok[pos] & (rvc | w_parcel_ok[pos_hi]);
      o_slot_avail[s] = chain;

      o_slot_pc[s] = w_line_base + {pos, 1'b0};

      pos               = rvc ? pos_hi : pos + 2'd2;
      o_slot_end_pos[s] = pos;
    end
  end

endmodule

`default_nettype wire

// File: ibuf_pkg.sv
`default_nettype none

package ibuf_pkg;

  // Coarse category used by the group limits
  typedef enum logic [2:0] {
    CAT_ARITH   = 3'd0,
    CAT_LD      = 3'd1,
    CAT_ST      = 3'd2,
    CAT_BR      = 3'd3,
    CAT_ILLEGAL = 3'd4
  } inst_cat_t;

  // Two parcels as assembled from the fetch lines
  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } inst_parcels_t;

  // Base 32-bit encoding fields
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_fields_t;

  typedef union packed {
    inst_parcels_t parcels;
    inst_fields_t  fields;
  } inst_word_u;

endpackage

`default_nettype wire

// File: ibuf_props.sv
`default_nettype none

`include "ibuf_macros.svh"

module ibuf_props
  import ibuf_pkg::*;
(
  input logic                  i_clk,
  input logic                  i_reset_n,
  input logic                  i_flush,
  input logic                  o_disp_valid,
  input logic [`IBUF_DISP-1:0] o_disp_slot_valid,
  input inst_cat_t             o_disp_cat [`IBUF_DISP]
);

  logic [2:0] w_mem_cnt;
  logic       w_br_mid;

  always_comb begin
    w_mem_cnt = '0;
    w_br_mid  = 1'b0;
    for (int s = 0; s < `IBUF_DISP; s++) begin
      if (o_disp_slot_valid[s] && (o_disp_cat[s] inside {CAT_LD, CAT_ST}))
        w_mem_cnt = w_mem_cnt + 3'd1;
      if (s < `IBUF_DISP - 1 && o_disp_slot_valid[s] && o_disp_cat[s] == CAT_BR &&
          o_disp_slot_valid[s+1])
        w_br_mid = 1'b1; // branch with a later slot
    end
  end

  a_contig: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_disp_slot_valid & (o_disp_slot_valid + 1'b1)) == '0) else $error("slots not contiguous");
  a_mem: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_mem_cnt <= `IBUF_MEM_DISP) else $error("too many memory slots");
  a_br_last: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !w_br_mid) else $error("branch not in last slot");
  a_flush: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_flush |-> !o_disp_valid) else $error("dispatch during flush");

endmodule

bind ibuf_top ibuf_props u_props (
  .i_clk             (i_clk),
  .i_reset_n         (i_reset_n),
  .i_flush           (i_flush),
  .o_disp_valid      (o_disp_valid),
  .o_disp_slot_valid (o_disp_slot_valid),
  .o_disp_cat        (o_disp_cat)
);

`default_nettype wire

// File: ibuf_top.sv
`default_nettype none

`include "ibuf_macros.svh"

module ibuf_top
  import ibuf_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_flush,

  input  logic                     i_fetch_valid,
  input  logic [`IBUF_VADDR_W-1:0] i_fetch_pc,
  input  logic [`IBUF_LINE_W-1:0]  i_fetch_line,
  output logic                     o_fetch_ready,

  output logic                     o_disp_valid,
  output logic [`IBUF_DISP-1:0]    o_disp_slot_valid,
  output logic [31:0]              o_disp_inst [`IBUF_DISP],
  output logic [`IBUF_DISP-1:0]    o_disp_rvc,
  output inst_cat_t                o_disp_cat  [`IBUF_DISP],
  output logic [`IBUF_VADDR_W-1:0] o_disp_pc   [`IBUF_DISP],
  input  logic                     i_disp_ready
);

  // Queue to extract
  logic [`IBUF_LINE_W-1:0]  w_head_line;
  logic [`IBUF_LINE_W-1:0]  w_next_line;
  logic                     w_head_valid;
  logic                     w_next_valid;
  logic [`IBUF_VADDR_W-1:0] w_head_pc;
  logic [`IBUF_POS_W-1:0]   w_head_pos;

  // Extract to classify and select
  inst_word_u               w_slot_word    [`IBUF_DISP];
  logic [`IBUF_DISP-1:0]    w_slot_rvc;
  logic [`IBUF_DISP-1:0]    w_slot_avail;
  logic [`IBUF_VADDR_W-1:0] w_slot_pc      [`IBUF_DISP];
  logic [`IBUF_POS_W:0]     w_slot_end_pos [`IBUF_DISP];
  inst_cat_t                w_slot_cat     [`IBUF_DISP];

  // Select back to queue
  logic                     w_fire;
  logic [`IBUF_POS_W:0]     w_adv_parcels;

  ibuf_line_queue u_queue (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_flush       (i_flush),
    .i_fetch_valid (i_fetch_valid),
    .i_fetch_pc    (i_fetch_pc),
    .i_fetch_line  (i_fetch_line),
    .o_fetch_ready (o_fetch_ready),
    .i_fire        (w_fire),
    .i_adv_parcels (w_adv_parcels),
    .o_head_line   (w_head_line),
    .o_next_line   (w_next_line),
    .o_head_valid  (w_head_valid),
    .o_next_valid  (w_next_valid),
    .o_head_pc     (w_head_pc),
    .o_head_pos    (w_head_pos)
  );

  ibuf_parcel_extract u_extract (
    .i_head_line    (w_head_line),
    .i_next_line    (w_next_line),
    .i_head_valid   (w_head_valid),
    .i_next_valid   (w_next_valid),
    .i_head_pc      (w_head_pc),
    .i_head_pos     (w_head_pos),
    .o_slot_word    (w_slot_word),
    .o_slot_rvc     (w_slot_rvc),
    .o_slot_avail   (w_slot_avail),
    .o_slot_pc      (w_slot_pc),
    .o_slot_end_pos (w_slot_end_pos)
  );

  ibuf_inst_classify u_classify (
    .i_slot_word (w_slot_word),
    .i_slot_rvc  (w_slot_rvc),
    .o_slot_cat  (w_slot_cat)
  );

  ibuf_group_select u_select (
    .i_flush           (i_flush),
    .i_disp_ready      (i_disp_ready),
    .i_slot_word       (w_slot_word),
    .i_slot_rvc        (w_slot_rvc),
    .i_slot_avail      (w_slot_avail),
    .i_slot_pc         (w_slot_pc),
    .i_slot_end_pos    (w_slot_end_pos),
    .i_slot_cat        (w_slot_cat),
    .o_disp_valid      (o_disp_valid),
    .o_disp_slot_valid (o_disp_slot_valid),
    .o_disp_inst       (o_disp_inst),
    .o_disp_rvc        (o_disp_rvc),
    .o_disp_cat        (o_disp_cat),
    .o_disp_pc         (o_disp_pc),
    .o_fire            (w_fire),
    .o_adv_parcels     (w_adv_parcels)
  );

endmodule

`default_nettype wire

// File: tb_ibuf.sv
`default_nettype none

`include "ibuf_macros.svh"

module tb_ibuf
  import ibuf_pkg::*;
();

  localparam int LINES     = 600;
  localparam int MAX_CYCLE = LINES * `IBUF_PARCELS * 8;

  logic                     i_clk;
  logic                     i_reset_n;
  logic                     i_flush;
  logic                     i_fetch_valid;
  logic [`IBUF_VADDR_W-1:0] i_fetch_pc;
  logic [`IBUF_LINE_W-1:0]  i_fetch_line;
  logic                     o_fetch_ready;
  logic                     o_disp_valid;
  logic [`IBUF_DISP-1:0]    o_disp_slot_valid;
  logic [31:0]              o_disp_inst [`IBUF_DISP];
  logic [`IBUF_DISP-1:0]    o_disp_rvc;
  inst_cat_t                o_disp_cat  [`IBUF_DISP];
  logic [`IBUF_VADDR_W-1:0] o_disp_pc   [`IBUF_DISP];
  logic                     i_disp_ready;

  ibuf_top dut0 (.*);

  logic [31:0] rng;
  logic [15:0] gen_q [$];   // Parcels of the stream not yet put in a line
  logic [15:0] mq_par [$];  // Model of the parcels held by the DUT
  logic [31:0] mq_pc [$];
  bit          mq_last [$];
  logic [15:0] line_par [`IBUF_PARCELS];
  logic [31:0] line_pc;
  logic [31:0] stream_pc;
  int          stream_off;
  int          line_off;
  int          occ;
  int          lines_sent;
  int          cycle_cnt;
  int          err_cnt;
  int          exp_adv;
  logic [3:0]  exp_valid;
  logic [3:0]  prev_valid;
  bit          prev_hold;

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > MAX_CYCLE) begin
      $display("timeout after %0d cycles, stream did not finish", cycle_cnt);
      fail_run();
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int rnd(input int n);
    rng = xorshift(rng);
    return int'(rng % n);
  endfunction

  // Category rules for the reference model
  function automatic inst_cat_t model_cat(input logic [15:0] lo);
    if (lo[1:0] != 2'b11) begin
      if (lo[1:0] == 2'b00 && lo[15:13] == 3'b010) return CAT_LD;
      if (lo[1:0] == 2'b00 && lo[15:13] == 3'b110) return CAT_ST;
      if (lo[1:0] == 2'b01 && lo[15:13] >= 3'b101) return CAT_BR;
      return CAT_ARITH;
    end
    case (lo[6:0])
      7'h03:                      return CAT_LD;
      7'h23:                      return CAT_ST;
      7'h63, 7'h6f, 7'h67:        return CAT_BR;
      7'h33, 7'h13, 7'h37, 7'h17: return CAT_ARITH;
      default:                    return CAT_ILLEGAL;
    endcase
  endfunction

  task automatic fail_run();
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input int slot, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp) else begin
      $display("error time %0t %s[%0d] got %h expected %h", $time, name, slot, got, exp);
      err_cnt++;
      fail_run();
    end
  endtask

  // ========================================
  // Stimulus
  // ========================================
  task automatic gen_inst();
    logic [31:0] w;
    int          k;
    k  = rnd(16);
    rng = xorshift(rng);
    w  = rng;
    if (k < 4) begin
      case (rnd(4))
        0: w[6:0] = 7'h33;
        1: w[6:0] = 7'h13;
        2: w[6:0] = 7'h37;
        default: w[6:0] = 7'h17;
      endcase
    end else if (k < 6) begin
      w[6:0] = 7'h03;
    end else if (k < 8) begin
      w[6:0] = 7'h23;
    end else if (k == 8) begin
      case (rnd(3))
        0: w[6:0] = 7'h63;
        1: w[6:0] = 7'h6f;
        default: w[6:0] = 7'h67;
      endcase
    end else if (k == 9) begin
      w[6:0] = {w[6:2], 2'b11}; // mostly unknown opcodes
    end else begin
      w[1:0] = 2'(rnd(3)); // Compressed quadrant 0 to 2
    end
    gen_q.push_back(w[15:0]);
    if (w[1:0] == 2'b11) gen_q.push_back(w[31:16]);
  endtask

  task automatic new_stream();
    rng = xorshift(rng);
    stream_pc  = {rng[31:4], 4'b0};
    stream_off = rnd(`IBUF_PARCELS);
    gen_q.delete();
  endtask

  task automatic make_line();
    line_off = stream_off;
    for (int p = 0; p < `IBUF_PARCELS; p++) begin
      if (p < line_off) begin
        line_par[p] = 16'(rnd(65536)); // never dispatched
      end else begin
        if (gen_q.size() == 0) gen_inst();
        line_par[p] = gen_q.pop_front();
      end
      i_fetch_line[p*16 +: 16] = line_par[p];
    end
    line_pc    = stream_pc + 32'(2 * line_off);
    i_fetch_pc = line_pc;
    stream_pc  = stream_pc + 32'd16;
    stream_off = 0;
  endtask

  // ========================================
  // Model check
  // ========================================
  task automatic check_outputs();
    logic [3:0]  ev;
    logic [31:0] ei [4];
    logic [31:0] ep [4];
    inst_cat_t   ec [4];
    logic [3:0]  er;
    int          idx;
    int          mem;
    int          len;
    bit          stop;
    idx  = 0;
    mem  = 0;
    stop = 0;
    ev   = '0;
    er   = '0;
    for (int s = 0; s < 4; s++) begin
      ei[s] = '0;
      ep[s] = '0;
      ec[s] = CAT_ARITH;
      if (!stop) begin
        len = (mq_par.size() > idx && mq_par[idx][1:0] != 2'b11) ? 1 : 2;
        if (idx + len > mq_par.size()) begin
          stop = 1;
        end else if (mem == `IBUF_MEM_DISP &&
                     (model_cat(mq_par[idx]) inside {CAT_LD, CAT_ST})) begin
          stop = 1;
        end else begin
          ev[s] = 1'b1;
          er[s] = (len == 1);
          ec[s] = model_cat(mq_par[idx]);
          ep[s] = mq_pc[idx];
          ei[s] = (len == 1) ? {16'h0, mq_par[idx]} : {mq_par[idx + 1], mq_par[idx]};
          if (ec[s] inside {CAT_LD, CAT_ST}) mem++;
          if (ec[s] inside {CAT_BR, CAT_ILLEGAL}) stop = 1;
          idx = idx + len;
        end
      end
    end
    exp_adv = idx;
    if (i_flush) begin
      ev = '0;
      er = '0;
      for (int s = 0; s < 4; s++) begin
        ei[s] = '0;
        ep[s] = '0;
        ec[s] = CAT_ARITH;
      end
    end
    exp_valid = ev;
    check_val("o_disp_valid", 0, 32'(o_disp_valid), 32'(|ev));
    check_val("o_disp_slot_valid", 0, 32'(o_disp_slot_valid), 32'(ev));
    check_val("o_disp_rvc", 0, 32'(o_disp_rvc), 32'(er));
    check_val("o_fetch_ready", 0, 32'(o_fetch_ready), 32'(occ < `IBUF_DEPTH));
    for (int s = 0; s < 4; s++) begin
      check_val("o_disp_inst", s, o_disp_inst[s], ei[s]);
      check_val("o_disp_pc", s, o_disp_pc[s], ep[s]);
      check_val("o_disp_cat", s, 32'(o_disp_cat[s]), 32'(ec[s]));
    end
    // Stalled group may only grow
    if (prev_hold && !i_flush) begin
      assert ((prev_valid & ~o_disp_slot_valid) == 4'b0) else begin
        $display("stalled group lost a slot at time %0t", $time);
        err_cnt++;
        fail_run();
      end
    end
  endtask

  task automatic update_model();
    if (i_flush) begin
      mq_par.delete();
      mq_pc.delete();
      mq_last.delete();
      occ = 0;
      new_stream();
    end else begin
      if (i_disp_ready && exp_valid != 4'b0) begin
        repeat (exp_adv) begin
          if (mq_last[0]) occ--;
          void'(mq_par.pop_front());
          void'(mq_pc.pop_front());
          void'(mq_last.pop_front());
        end
      end
      if (i_fetch_valid && occ < `IBUF_DEPTH) begin
        for (int p = line_off; p < `IBUF_PARCELS; p++) begin
          mq_par.push_back(line_par[p]);
          mq_pc.push_back({line_pc[31:4], 4'b0} + 32'(2 * p));
          mq_last.push_back(p == `IBUF_PARCELS - 1);
        end
        occ++;
        lines_sent++;
      end
    end
    prev_hold  = !i_disp_ready && !i_flush;
    prev_valid = exp_valid;
  endtask

  initial begin
    int step;
    rng           = 32'hf580;
    i_reset_n     = 1'b0;
    i_flush       = 1'b0;
    i_fetch_valid = 1'b0;
    i_fetch_pc    = '0;
    i_fetch_line  = '0;
    i_disp_ready  = 1'b0;
    cycle_cnt     = 0;
    err_cnt       = 0;
    occ           = 0;
    lines_sent    = 0;
    exp_valid     = '0;
    prev_hold     = 0;
    prev_valid    = '0;
    step          = 0;
    new_stream();
    repeat (10) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    while (lines_sent < LINES || step < 60000) begin
      @(negedge i_clk);
      if (lines_sent >= LINES) step = step + 1000; // drain phase
      // First cycles fill the queue with dispatch stalled
      i_flush       = (step >= 5) && (rnd(64) == 0);
      i_disp_ready  = (step >= 5) && (rnd(4) != 0);
      i_fetch_valid = 1'b0;
      if (!i_flush && o_fetch_ready && lines_sent < LINES && (step < 5 || rnd(4) != 0)) begin
        make_line();
        i_fetch_valid = 1'b1;
      end
      #1;
      if (step == 4) check_val("o_fetch_ready", 0, 32'(o_fetch_ready), 32'd0);
      check_outputs();
      update_model();
      step++;
    end
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
ibuf_pkg.sv
ibuf_line_queue.sv
ibuf_parcel_extract.sv
ibuf_inst_classify.sv
ibuf_group_select.sv
ibuf_top.sv
ibuf_props.sv
tb_ibuf.sv
